// ==== source/core_settings.svh ====
// core width and depth settings

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define IMEM_AW 8 // instruction address bits, in words.
`define INSTR_W 16 // instruction word.
`define XLEN 16 // register and data width.
`define REG_AW 3 // 8 registers.
`define IMM_W 6 // raw immediate field.

// packed micro-op: opcode, rd, rs, imm, pc
`define UOP_W (4 + `REG_AW + `REG_AW + `XLEN + `IMEM_AW)

`define FIFO_AW 2 // 4 entries.

`endif

// ==== source/core_pkg.sv ====
// core shared types

package core_pkg;

	//////////////////////////////
	// opcodes, top 4 bits of the instruction word
	//////////////////////////////

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0, // also taken by every unused code.
		OP_ADDI = 4'h1, // rd = rs + imm.
		OP_ADD  = 4'h2, // rd = rd + rs.
		OP_SUB  = 4'h3, // rd = rd - rs.
		OP_BNE  = 4'h4, // pc = pc + imm if rd != rs.
		OP_OUT  = 4'h5  // emit rs.
	} opcode_e;

	//////////////////////////////
	// execute unit states
	//////////////////////////////

	typedef enum logic [1:0] {
		ST_RUN,     // popping and executing.
		ST_OUT_REQ, // out_req high, waiting for ack.
		ST_OUT_REL  // waiting for ack to drop.
	} exec_state_e;

endpackage

// ==== source/fetch_unit.sv ====
// instruction fetch unit

`timescale 1ns/1ps

`include "core_settings.svh"

module fetch_unit import core_pkg::*; (
	input  logic                CLK,
	input  logic                rst,

	output logic                imem_req,
	output logic [`IMEM_AW-1:0] imem_addr,
	input  logic                imem_ack,
	input  logic [`INSTR_W-1:0] imem_data,

	output logic                push,
	input  logic                full,
	output opcode_e             uop_op,
	output logic [`REG_AW-1:0]  uop_rd,
	output logic [`REG_AW-1:0]  uop_rs,
	output logic [`XLEN-1:0]    uop_imm,
	output logic [`IMEM_AW-1:0] uop_pc,

	input  logic                redirect_valid,
	input  logic [`IMEM_AW-1:0] redirect_pc
);

	typedef enum logic [1:0] {
		F_IDLE, // out of reset.
		F_REQ,  // request phase.
		F_REL,  // release phase.
		F_HOLD  // word held until the fifo takes it.
	} fetch_state_e;

	fetch_state_e        state;
	logic [`IMEM_AW-1:0] pc_q; // address of the word in flight or held.
	logic [`IMEM_AW-1:0] redir_pc_q; // target saved during a handshake.
	logic                drop_q; // in-flight word belongs to a flushed path.
	logic [`INSTR_W-1:0] instr_q;

	//////////////////////////////
	// request state machine
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state      <= F_IDLE;
			pc_q       <= '0;
			redir_pc_q <= '0;
			drop_q     <= 1'b0;
		end else begin
			case (state)
				F_IDLE: begin
					if (redirect_valid)
						pc_q <= redirect_pc;
					state <= F_REQ;
				end
				F_REQ: begin
					// address must not move until the memory answers.
					if (redirect_valid) begin
						drop_q     <= 1'b1;
						redir_pc_q <= redirect_pc;
					end
					if (imem_ack)
						state <= F_REL;
				end
				F_REL: begin
					if (!imem_ack) begin
						if (redirect_valid) begin
							pc_q   <= redirect_pc;
							drop_q <= 1'b0;
							state  <= F_REQ;
						end else if (drop_q) begin
							pc_q   <= redir_pc_q; // stale word, refetch.
							drop_q <= 1'b0;
							state  <= F_REQ;
						end else begin
							state <= F_HOLD;
						end
					end else if (redirect_valid) begin
						drop_q     <= 1'b1;
						redir_pc_q <= redirect_pc;
					end
				end
				F_HOLD: begin
					if (redirect_valid) begin
						pc_q  <= redirect_pc; // held word dropped.
						state <= F_REQ;
					end else if (!full) begin
						pc_q  <= pc_q + 1'b1; // predict not-taken.
						state <= F_REQ;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == F_REQ && imem_ack)
			instr_q <= imem_data;
	end

	assign imem_req  = (state == F_REQ);
	assign imem_addr = pc_q;
	assign push      = (state == F_HOLD) && !full;

	// predecode of the held word
	assign uop_op  = opcode_e'(instr_q[`INSTR_W-1 -: 4]);
	assign uop_rd  = instr_q[`INSTR_W-5 -: `REG_AW];
	assign uop_rs  = instr_q[`INSTR_W-5-`REG_AW -: `REG_AW];
	assign uop_imm = {{(`XLEN-`IMM_W){instr_q[`IMM_W-1]}}, instr_q[`IMM_W-1:0]};
	assign uop_pc  = pc_q;

	a_addr_stable: assert property (@(posedge CLK) disable iff (rst)
		imem_req && !imem_ack |=> $stable(imem_addr));

endmodule

// ==== source/instr_fifo.sv ====
// synchronous instruction fifo

`timescale 1ns/1ps

module instr_fifo #(
	parameter int DW = 32,
	parameter int AW = 2
) (
	input  logic          CLK,
	input  logic          rst,

	input  logic          push,
	input  logic [DW-1:0] din,
	output logic          full,

	input  logic          pop,
	output logic [DW-1:0] dout,
	output logic          empty,

	input  logic          flush
);

	localparam int DEPTH = 1 << AW;

	logic [DW-1:0] mem [0:DEPTH-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			wr_ptr <= '0; // flush beats a same-cycle push.
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	assign full  = (count == DEPTH);
	assign empty = (count == '0);
	assign dout  = mem[rd_ptr]; // head, shown without a read cycle.

	a_no_overflow: assert property (@(posedge CLK) disable iff (rst) !(push && full && !flush));
	a_no_underflow: assert property (@(posedge CLK) disable iff (rst) !(pop && empty));

endmodule

// ==== source/exec_unit.sv ====
// execute unit

`timescale 1ns/1ps

`include "core_settings.svh"

module exec_unit import core_pkg::*; (
	input  logic                CLK,
	input  logic                rst,

	input  logic                empty,
	output logic                pop,
	input  opcode_e             uop_op,
	input  logic [`REG_AW-1:0]  uop_rd,
	input  logic [`REG_AW-1:0]  uop_rs,
	input  logic [`XLEN-1:0]    uop_imm,
	input  logic [`IMEM_AW-1:0] uop_pc,

	output logic                redirect_valid,
	output logic [`IMEM_AW-1:0] redirect_pc,

	output logic                out_req,
	output logic [`XLEN-1:0]    out_data,
	input  logic                out_ack
);

	localparam int NREG = 1 << `REG_AW;

	exec_state_e      state;
	logic [`XLEN-1:0] rf [1:NREG-1]; // r0 is not stored.
	logic [`XLEN-1:0] rd_val;
	logic [`XLEN-1:0] rs_val;
	logic             rf_we;
	logic [`XLEN-1:0] rf_wdata;
	logic             out_load;

	//////////////////////////////
	// operand read
	//////////////////////////////

	assign rd_val = (uop_rd == '0) ? '0 : rf[uop_rd];
	assign rs_val = (uop_rs == '0) ? '0 : rf[uop_rs];

	//////////////////////////////
	// issue and alu
	//////////////////////////////

	always_comb begin
		pop            = 1'b0;
		rf_we          = 1'b0;
		rf_wdata       = '0;
		redirect_valid = 1'b0;
		out_load       = 1'b0;
		if (state == ST_RUN && !empty) begin
			pop = 1'b1; // one per cycle.
			case (uop_op)
				OP_ADDI: begin
					rf_we    = 1'b1;
					rf_wdata = rs_val + uop_imm;
				end
				OP_ADD: begin
					rf_we    = 1'b1;
					rf_wdata = rd_val + rs_val;
				end
				OP_SUB: begin
					rf_we    = 1'b1;
					rf_wdata = rd_val - rs_val;
				end
				OP_BNE: begin
					redirect_valid = (rd_val != rs_val); // taken means mispredicted.
				end
				OP_OUT: begin
					out_load = 1'b1;
				end
				default: begin
					// nop and unused codes.
				end
			endcase
		end
	end

	assign redirect_pc = uop_pc + uop_imm[`IMEM_AW-1:0];

	// architectural state starts at zero
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 1; i < NREG; i++)
				rf[i] <= '0;
		end else if (rf_we && uop_rd != '0) begin
			rf[uop_rd] <= rf_wdata;
		end
	end

	//////////////////////////////
	// output handshake
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= ST_RUN;
		end else begin
			case (state)
				ST_RUN: begin
					if (out_load)
						state <= ST_OUT_REQ;
				end
				ST_OUT_REQ: begin
					if (out_ack)
						state <= ST_OUT_REL;
				end
				ST_OUT_REL: begin
					if (!out_ack)
						state <= ST_RUN; // four phases done.
				end
				default: state <= ST_RUN;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (out_load)
			out_data <= rs_val;
	end

	assign out_req = (state == ST_OUT_REQ);

	a_out_stable: assert property (@(posedge CLK) disable iff (rst)
		out_req && !out_ack |=> out_req && $stable(out_data));

endmodule

// ==== source/core_top.sv ====
// in-order core top level

`timescale 1ns/1ps

`include "core_settings.svh"

module core_top import core_pkg::*; (
	input  logic                CLK,
	input  logic                rst,

	output logic                imem_req,
	output logic [`IMEM_AW-1:0] imem_addr,
	input  logic                imem_ack,
	input  logic [`INSTR_W-1:0] imem_data,

	output logic                out_req,
	output logic [`XLEN-1:0]    out_data,
	input  logic                out_ack
);

	logic                push;
	logic                full;
	opcode_e             push_op;
	logic [`REG_AW-1:0]  push_rd;
	logic [`REG_AW-1:0]  push_rs;
	logic [`XLEN-1:0]    push_imm;
	logic [`IMEM_AW-1:0] push_pc;
	logic [`UOP_W-1:0]   push_word;

	logic                pop;
	logic                empty;
	logic [`UOP_W-1:0]   pop_word;
	logic [3:0]          pop_op_bits;
	logic [`REG_AW-1:0]  pop_rd;
	logic [`REG_AW-1:0]  pop_rs;
	logic [`XLEN-1:0]    pop_imm;
	logic [`IMEM_AW-1:0] pop_pc;

	logic                redirect_valid; // also flushes the fifo.
	logic [`IMEM_AW-1:0] redirect_pc;

	assign push_word = {push_op, push_rd, push_rs, push_imm, push_pc};
	assign {pop_op_bits, pop_rd, pop_rs, pop_imm, pop_pc} = pop_word;

	fetch_unit u_fetch (
		.CLK            (CLK),
		.rst            (rst),
		.imem_req       (imem_req),
		.imem_addr      (imem_addr),
		.imem_ack       (imem_ack),
		.imem_data      (imem_data),
		.push           (push),
		.full           (full),
		.uop_op         (push_op),
		.uop_rd         (push_rd),
		.uop_rs         (push_rs),
		.uop_imm        (push_imm),
		.uop_pc         (push_pc),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	instr_fifo #(.DW(`UOP_W), .AW(`FIFO_AW)) u_fifo (
		.CLK   (CLK),
		.rst   (rst),
		.push  (push),
		.din   (push_word),
		.full  (full),
		.pop   (pop),
		.dout  (pop_word),
		.empty (empty),
		.flush (redirect_valid)
	);

	exec_unit u_exec (
		.CLK            (CLK),
		.rst            (rst),
		.empty          (empty),
		.pop            (pop),
		.uop_op         (opcode_e'(pop_op_bits)),
		.uop_rd         (pop_rd),
		.uop_rs         (pop_rs),
		.uop_imm        (pop_imm),
		.uop_pc         (pop_pc),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.out_req        (out_req),
		.out_data       (out_data),
		.out_ack        (out_ack)
	);

endmodule

// ==== test/core_tb_imem.sv ====
// instruction memory and output responder

`timescale 1ns/1ps

`include "core_settings.svh"

module core_tb_imem import core_pkg::*; (
	input  logic                clk,
	input  logic                rst,

	input  logic                imem_req,
	input  logic [`IMEM_AW-1:0] imem_addr,
	output logic                imem_ack,
	output logic [`INSTR_W-1:0] imem_data,

	input  logic                out_req,
	output logic                out_ack
);

	logic [`INSTR_W-1:0] prog [0:(1<<`IMEM_AW)-1];
	logic [15:0]         lfsr = 16'd32211;
	logic                imem_busy;
	logic [2:0]          imem_cnt;
	logic                out_busy;
	logic [2:0]          out_cnt;

	// layout is op, rd, rs, imm from the top bit down
	function automatic logic [`INSTR_W-1:0] enc(opcode_e op, int rd, int rs, int imm);
		return {op, rd[`REG_AW-1:0], rs[`REG_AW-1:0], imm[`IMM_W-1:0]};
	endfunction

	// galois form, taps 16 14 13 11.
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function logic [2:0] draw_delay();
		logic [2:0] d;
		for (int k = 0; k < 3; k++) begin
			d[k] = lfsr[0]; // one step per bit.
			lfsr = lfsr_next(lfsr);
		end
		return d;
	endfunction

	//////////////////////////////
	// program image
	//////////////////////////////

	initial begin
		imem_ack  = 1'b0;
		imem_data = '0;
		out_ack   = 1'b0;
		imem_busy = 1'b0;
		imem_cnt  = '0;
		out_busy  = 1'b0;
		out_cnt   = '0;
		for (int a = 0; a < (1 << `IMEM_AW); a++)
			prog[a] = {8'h00, a[7:0]}; // nop tagged with its address.
		prog[0]  = enc(OP_ADDI, 1, 0, 5);
		prog[1]  = enc(OP_OUT,  0, 1, 0);
		prog[2]  = enc(OP_ADDI, 2, 0, -3);
		prog[3]  = enc(OP_OUT,  0, 2, 0);
		prog[4]  = enc(OP_ADD,  1, 2, 0);
		prog[5]  = enc(OP_OUT,  0, 1, 0);
		prog[6]  = enc(OP_SUB,  2, 1, 0);
		prog[7]  = enc(OP_OUT,  0, 2, 0);
		prog[8]  = enc(OP_ADDI, 5, 2, 10); // wraps past zero.
		prog[9]  = enc(OP_OUT,  0, 5, 0);
		prog[10] = enc(OP_ADDI, 4, 0, -32);
		prog[11] = enc(OP_ADD,  4, 4, 0);
		prog[12] = enc(OP_OUT,  0, 4, 0);
		prog[13] = enc(OP_ADDI, 0, 1, 7); // r0 writes.
		prog[14] = enc(OP_ADD,  0, 4, 0);
		prog[15] = enc(OP_OUT,  0, 0, 0);
		prog[16] = enc(OP_ADDI, 6, 0, 3); // countdown loop.
		prog[17] = enc(OP_OUT,  0, 6, 0);
		prog[18] = enc(OP_ADDI, 6, 6, -1);
		prog[19] = enc(OP_BNE,  6, 0, -2);
		prog[20] = enc(OP_OUT,  0, 1, 0);
		prog[21] = enc(OP_BNE,  1, 0, 2);
		prog[22] = enc(OP_OUT,  0, 4, 0); // skipped.
		for (int i = 0; i < 12; i++)
			prog[23 + i] = enc(OP_OUT, 0, i % 7 + 1, 0);
		prog[35] = enc(OP_BNE, 1, 0, 0); // branch to itself.
	end

	//////////////////////////////
	// responders
	//////////////////////////////

	always @(posedge clk) begin
		if (rst) begin
			imem_ack  <= 1'b0;
			out_ack   <= 1'b0;
			imem_busy <= 1'b0;
			out_busy  <= 1'b0;
		end else begin
			if (imem_req && !imem_ack) begin
				if (!imem_busy) begin
					imem_busy <= 1'b1;
					imem_cnt  <= draw_delay();
				end else if (imem_cnt != 0) begin
					imem_cnt <= imem_cnt - 1'b1;
				end else begin
					imem_ack  <= 1'b1;
					imem_data <= prog[imem_addr];
					imem_busy <= 1'b0;
				end
			end else if (!imem_req && imem_ack) begin
				imem_ack <= 1'b0; // release at once.
			end
			// out_ack follows out_req late on both edges
			if (out_req != out_ack) begin
				if (!out_busy) begin
					out_busy <= 1'b1;
					out_cnt  <= draw_delay();
				end else if (out_cnt != 0) begin
					out_cnt <= out_cnt - 1'b1;
				end else begin
					out_ack  <= out_req;
					out_busy <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== test/core_tb.sv ====
// core testbench

`timescale 1ns/1ps

`include "core_settings.svh"

module core_tb import core_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 120;
	localparam int MAX_STEPS    = 1000;

	logic                clk = 1'b0;
	logic                rst = 1'b1;
	logic                imem_req;
	logic [`IMEM_AW-1:0] imem_addr;
	logic                imem_ack;
	logic [`INSTR_W-1:0] imem_data;
	logic                out_req;
	logic [`XLEN-1:0]    out_data;
	logic                out_ack;

	logic [`XLEN-1:0]    exp_q[$];
	string               name_q[$];
	logic [`XLEN-1:0]    exp_head;
	string               head_name;
	int                  exp_left;
	int                  model_steps;
	logic [`IMEM_AW-1:0] halt_pc; // address of the closing self-branch.
	logic                rst_q = 1'b0;
	logic                fetch_seen = 1'b0;
	logic                out_req_q = 1'b0;

	always #50 clk = ~clk;

	core_top u_core_top (
		.CLK       (clk),
		.rst       (rst),
		.imem_req  (imem_req),
		.imem_addr (imem_addr),
		.imem_ack  (imem_ack),
		.imem_data (imem_data),
		.out_req   (out_req),
		.out_data  (out_data),
		.out_ack   (out_ack)
	);

	core_tb_imem u_imem (
		.clk       (clk),
		.rst       (rst),
		.imem_req  (imem_req),
		.imem_addr (imem_addr),
		.imem_ack  (imem_ack),
		.imem_data (imem_data),
		.out_req   (out_req),
		.out_ack   (out_ack)
	);

	task automatic report_error(string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(string test, logic [`XLEN-1:0] expected,
		logic [`XLEN-1:0] actual);
		report_error($sformatf("mismatch %s: expected %h, actual %h", test, expected, actual));
	endtask

	function automatic string section_of(logic [`IMEM_AW-1:0] pc);
		if (pc < 13)
			return "arith";
		if (pc < 16)
			return "reg0";
		if (pc < 23)
			return "branch";
		return "backpressure";
	endfunction

	task automatic load_head();
		exp_left = exp_q.size();
		if (exp_left != 0) begin
			exp_head  = exp_q[0];
			head_name = name_q[0];
		end
	endtask

	//////////////////////////////
	// architectural model
	//////////////////////////////

	task automatic run_model();
		logic [`XLEN-1:0]    regs [0:(1<<`REG_AW)-1];
		logic [`INSTR_W-1:0] instr;
		logic [`IMEM_AW-1:0] pc;
		logic [`REG_AW-1:0]  rd;
		logic [`REG_AW-1:0]  rs;
		logic [`XLEN-1:0]    imm;
		logic                halted;
		foreach (regs[i])
			regs[i] = '0;
		pc = '0;
		halted = 1'b0;
		model_steps = 0;
		while (!halted && model_steps < MAX_STEPS) begin
			instr = u_imem.prog[pc];
			rd = instr[11:9];
			rs = instr[8:6];
			imm = 16'($signed(instr[5:0]));
			model_steps++;
			case (instr[15:12])
				OP_ADDI: if (rd != 0) regs[rd] = regs[rs] + imm;
				OP_ADD:  if (rd != 0) regs[rd] = regs[rd] + regs[rs];
				OP_SUB:  if (rd != 0) regs[rd] = regs[rd] - regs[rs];
				OP_OUT: begin
					exp_q.push_back(regs[rs]);
					name_q.push_back(section_of(pc));
				end
				default: ;
			endcase
			if (instr[15:12] == OP_BNE && regs[rd] != regs[rs]) begin
				halted = (imm == 0); // self loop ends the program.
				pc = pc + imm[`IMEM_AW-1:0];
			end else begin
				pc = pc + 1'b1;
			end
		end
		halt_pc = pc;
	endtask

	// head moves on once a handshake completes.
	always @(posedge clk) begin
		rst_q     <= rst;
		out_req_q <= out_req;
		if (imem_req)
			fetch_seen <= 1'b1;
		if (out_req_q && !out_req && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			void'(name_q.pop_front());
			load_head();
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_reset_quiet: assert property (@(posedge clk) rst_q && rst |-> !imem_req && !out_req)
		else report_error("imem_req or out_req was high during reset");
	a_first_fetch: assert property (@(posedge clk) disable iff (rst)
		imem_req && !fetch_seen |-> imem_addr == '0)
		else report_mismatch("reset", '0, $sampled(imem_addr));
	a_out_expected: assert property (@(posedge clk) disable iff (rst)
		$rose(out_req) |-> exp_left != 0)
		else report_error("out_req rose with no output left in the model");
	a_out_value: assert property (@(posedge clk) disable iff (rst)
		$rose(out_req) && exp_left != 0 |-> out_data == exp_head)
		else report_mismatch(head_name, exp_head, $sampled(out_data));
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_req && $past(out_req) |-> $stable(out_data))
		else report_error("out_data changed while out_req was high");

	initial begin
		#1;
		run_model();
		load_head();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		// the core parks on the closing self-branch
		while (!(imem_req && imem_addr == halt_pc))
			@(negedge clk);
		repeat (DRAIN_CYCLES) @(negedge clk); // an extra output trips a check.
		if (exp_q.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			report_error($sformatf("%0d expected outputs never appeared", exp_q.size()));
		end
	end

	initial begin
		wait (!rst);
		repeat (model_steps * 20) @(posedge clk);
		report_error("watchdog expired, the core stopped making progress");
	end

endmodule

// ==== sources.f ====
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/instr_fifo.sv
source/exec_unit.sv
source/core_top.sv
test/core_tb_imem.sv
test/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

export_include_dirs:
  - source

sources:
  - source/core_pkg.sv
  - source/fetch_unit.sv
  - source/instr_fifo.sv
  - source/exec_unit.sv
  - source/core_top.sv
  - target: test
    files:
      - test/core_tb_imem.sv
      - test/core_tb.sv
